// File: rtl/orao_bus_pkg.sv
package orao_bus_pkg;

   ////////////////////
   // Memory map
   ////////////////////

   // Main RAM runs from 0000 up to RAM_TOP
   localparam logic [15:0] RAM_TOP = 16'h6000;
   // Video RAM occupies one 8 KB page
   localparam logic [15:0] VRAM_BASE = 16'h6000;
   // I/O page, speaker below SPK_LIMIT and keyboard above
   localparam logic [15:0] IO_BASE = 16'h8000;
   localparam logic [15:0] SPK_LIMIT = 16'h8800;

   // Value seen on reads from holes in the map
   localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

   // Keyboard matrix, 16 rows of 8 columns
   localparam int KEY_ROWS = 16;

   ////////////////////
   // Bus types
   ////////////////////

   // One cycle of the CPU memory bus
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we;
   } cpu_bus_t;

   // Decoded address region
   typedef enum logic [1:0] {
      REG_RAM,
      REG_VRAM,
      REG_IO,
      REG_NONE
   } region_e;

   // PS/2 key event, new event on each strobe toggle
   typedef struct packed {
      logic       strobe;
      logic       pressed;
      logic       extended;
      logic [7:0] code;
   } ps2_event_t;

endpackage

// File: rtl/orao_video_pkg.sv
package orao_video_pkg;

   ////////////////////
   // Horizontal timing
   ////////////////////

   // Counted in pixel clocks from the first visible pixel
   localparam int H_VISIBLE    = 256;
   localparam int H_SYNC_START = 272;
   localparam int H_SYNC_END   = 304;
   localparam int H_TOTAL      = 320;

   ////////////////////
   // Vertical timing
   ////////////////////

   // Counted in lines from the first visible line
   localparam int V_VISIBLE    = 256;
   localparam int V_SYNC_START = 260;
   localparam int V_SYNC_END   = 264;
   localparam int V_TOTAL      = 280;

   // One bit per pixel, 8 pixels per byte
   localparam int BYTES_PER_LINE = 32;
   // 8 KB of video RAM
   localparam int VRAM_AW = 13;

   // Video outputs, all aligned to the same cycle
   // Syncs are active low
   typedef struct packed {
      logic pix;
      logic hsync;
      logic vsync;
      logic hblank;
      logic vblank;
      logic de;
   } video_out_t;

endpackage

// File: rtl/orao_ram.sv
`timescale 1ns/1ps

module orao_ram (
   input  logic        clk,
   input  logic        we,
   input  logic [14:0] addr,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata
);

   // 24 KB of main RAM, depth follows the memory map
   logic [7:0] mem [orao_bus_pkg::RAM_TOP];

   // Single port, read-first
   // Read data shows the old byte on a write to the same address
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

// File: rtl/orao_vram.sv
`timescale 1ns/1ps

module orao_vram (
   input  logic                               clk,

   // CPU side
   input  logic                               a_we,
   input  logic [orao_video_pkg::VRAM_AW-1:0] a_addr,
   input  logic [7:0]                         a_wdata,
   output logic [7:0]                         a_rdata,

   // Scanner side, read only
   input  logic [orao_video_pkg::VRAM_AW-1:0] b_addr,
   output logic [7:0]                         b_rdata
);

   // 8 KB frame buffer, 32 bytes per line
   logic [7:0] mem [2**orao_video_pkg::VRAM_AW];

   ////////////////////
   // Port A
   ////////////////////

   // CPU read and write, read-first
   always_ff @(posedge clk) begin
      if (a_we) begin
         mem[a_addr] <= a_wdata;
      end
      a_rdata <= mem[a_addr];
   end

   ////////////////////
   // Port B
   ////////////////////

   // Scanner fetch, byte one cycle after the address
   always_ff @(posedge clk) begin
      b_rdata <= mem[b_addr];
   end

endmodule

// File: rtl/orao_video.sv
`timescale 1ns/1ps

module orao_video (
   input  logic                               clk,
   input  logic                               reset,
   output logic [orao_video_pkg::VRAM_AW-1:0] vram_addr,
   input  logic [7:0]                         vram_data,
   output orao_video_pkg::video_out_t         video
);

   // Raster position
   logic [8:0] h_cnt;
   logic [8:0] v_cnt;
   logic       h_vis;
   logic       v_vis;

   // Stage 1 timing and byte load flag
   orao_video_pkg::video_out_t timing_s1;
   logic                       load_s1;

   // Pixel shifter
   logic [7:0] shift_q;
   logic       pix_bit;

   // Stage 2, what leaves the module
   orao_video_pkg::video_out_t timing_s2;

   ////////////////////
   // Raster counters
   ////////////////////

   // Free running from reset, wrap at the totals
   always_ff @(posedge clk) begin
      if (reset) begin
         h_cnt <= 9'd0;
         v_cnt <= 9'd0;
      end else if (h_cnt == 9'(orao_video_pkg::H_TOTAL - 1)) begin
         h_cnt <= 9'd0;
         if (v_cnt == 9'(orao_video_pkg::V_TOTAL - 1)) begin
            v_cnt <= 9'd0;
         end else begin
            v_cnt <= v_cnt + 9'd1;
         end
      end else begin
         h_cnt <= h_cnt + 9'd1;
      end
   end

   assign h_vis = (h_cnt < 9'(orao_video_pkg::H_VISIBLE));
   assign v_vis = (v_cnt < 9'(orao_video_pkg::V_VISIBLE));

   ////////////////////
   // Byte fetch
   ////////////////////

   // Byte y*32 + x/8, only meaningful in the visible area
   assign vram_addr = 13'(v_cnt[7:0]) * 13'(orao_video_pkg::BYTES_PER_LINE)
                    + 13'(h_cnt[7:3]);

   // Stage 1, timing from the counters
   // Pixel field stays 0 here, it joins in stage 2
   always_ff @(posedge clk) begin
      if (reset) begin
         timing_s1 <= '{pix: 1'b0, hsync: 1'b1, vsync: 1'b1,
                        hblank: 1'b1, vblank: 1'b1, de: 1'b0};
         load_s1   <= 1'b0;
      end else begin
         timing_s1.pix    <= 1'b0;
         timing_s1.hsync  <= !(h_cnt >= 9'(orao_video_pkg::H_SYNC_START) &&
                               h_cnt <  9'(orao_video_pkg::H_SYNC_END));
         timing_s1.vsync  <= !(v_cnt >= 9'(orao_video_pkg::V_SYNC_START) &&
                               v_cnt <  9'(orao_video_pkg::V_SYNC_END));
         timing_s1.hblank <= !h_vis;
         timing_s1.vblank <= !v_vis;
         timing_s1.de     <= h_vis && v_vis;
         // First pixel of an 8-pixel group
         load_s1          <= h_vis && v_vis && (h_cnt[2:0] == 3'd0);
      end
   end

   ////////////////////
   // Pixel shifter
   ////////////////////

   // Bit 0 is the leftmost pixel, taken straight from the fetched byte
   assign pix_bit = load_s1 ? vram_data[0] : shift_q[0];

   // Remaining 7 bits shift out LSB first
   always_ff @(posedge clk) begin
      if (load_s1) begin
         shift_q <= {1'b0, vram_data[7:1]};
      end else begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   // Stage 2, pixel lined up with its timing
   always_ff @(posedge clk) begin
      if (reset) begin
         timing_s2 <= '{pix: 1'b0, hsync: 1'b1, vsync: 1'b1,
                        hblank: 1'b1, vblank: 1'b1, de: 1'b0};
      end else begin
         timing_s2 <= '{pix: timing_s1.de & pix_bit,
                        hsync: timing_s1.hsync,
                        vsync: timing_s1.vsync,
                        hblank: timing_s1.hblank,
                        vblank: timing_s1.vblank,
                        de: timing_s1.de};
      end
   end

   assign video = timing_s2;

endmodule

// File: rtl/orao_io.sv
`timescale 1ns/1ps

module orao_io (
   input  logic                     clk,
   input  logic                     reset,
   input  orao_bus_pkg::cpu_bus_t   bus,
   input  logic                     io_we,
   input  orao_bus_pkg::ps2_event_t ps2_key,
   output logic [7:0]               rdata,
   output logic                     audio
);

   // Previous strobe, a change marks a new event
   logic       strobe_q;
   logic       key_valid;
   logic [3:0] key_row;
   logic [2:0] key_col;

   // Key matrix, active low, one row per byte
   logic [7:0] key_rows [orao_bus_pkg::KEY_ROWS];

   // Own page check on the bus
   orao_bus_pkg::region_e sel;

   ////////////////////
   // Keyboard matrix
   ////////////////////

   // Extended codes and codes of 80 and up have no matrix position
   assign key_valid = (ps2_key.strobe != strobe_q) && !ps2_key.extended &&
                      !ps2_key.code[7];
   assign key_row   = ps2_key.code[6:3];
   assign key_col   = ps2_key.code[2:0];

   always_ff @(posedge clk) begin
      // Follows the strobe through reset so no event fires on release
      strobe_q <= ps2_key.strobe;
      if (reset) begin
         for (int r = 0; r < orao_bus_pkg::KEY_ROWS; r++) begin
            key_rows[r] <= 8'hFF;
         end
      end else if (key_valid) begin
         // Press pulls the bit low, release sets it again
         key_rows[key_row][key_col] <= !ps2_key.pressed;
      end
   end

   ////////////////////
   // Read back
   ////////////////////

   assign sel = (bus.addr[15:13] == orao_bus_pkg::IO_BASE[15:13]) ?
                orao_bus_pkg::REG_IO : orao_bus_pkg::REG_NONE;

   // Keyboard rows at 8800 and up, row from addr[3:0]
   always_ff @(posedge clk) begin
      if (sel == orao_bus_pkg::REG_IO && bus.addr >= orao_bus_pkg::SPK_LIMIT) begin
         rdata <= key_rows[bus.addr[3:0]];
      end else begin
         rdata <= orao_bus_pkg::UNMAPPED_DATA;
      end
   end

   ////////////////////
   // Speaker
   ////////////////////

   // Any write below 8800 flips the output, data is ignored
   always_ff @(posedge clk) begin
      if (reset) begin
         audio <= 1'b0;
      end else if (io_we && bus.addr < orao_bus_pkg::SPK_LIMIT) begin
         audio <= !audio;
      end
   end

endmodule

// File: rtl/orao_hw.sv
`timescale 1ns/1ps

module orao_hw (
   input  logic                       clk,
   input  logic                       reset,
   input  orao_bus_pkg::cpu_bus_t     bus,
   output logic [7:0]                 data_out,
   output orao_video_pkg::video_out_t video,
   input  orao_bus_pkg::ps2_event_t   ps2_key,
   output logic                       audio
);

   ////////////////////
   // Address decode
   ////////////////////

   orao_bus_pkg::region_e region;
   orao_bus_pkg::region_e region_q;
   logic                  ram_we;
   logic                  vram_we;
   logic                  io_we;

   // RAM below 6000, VRAM and I/O one 8 KB page each, rest unmapped
   always_comb begin
      if (bus.addr < orao_bus_pkg::RAM_TOP) begin
         region = orao_bus_pkg::REG_RAM;
      end else if (bus.addr >= orao_bus_pkg::VRAM_BASE &&
                   bus.addr < orao_bus_pkg::IO_BASE) begin
         region = orao_bus_pkg::REG_VRAM;
      end else if (bus.addr[15:13] == orao_bus_pkg::IO_BASE[15:13]) begin
         region = orao_bus_pkg::REG_IO;
      end else begin
         region = orao_bus_pkg::REG_NONE;
      end
   end

   // At most one enable, unmapped writes go nowhere
   assign ram_we  = bus.we && (region == orao_bus_pkg::REG_RAM);
   assign vram_we = bus.we && (region == orao_bus_pkg::REG_VRAM);
   assign io_we   = bus.we && (region == orao_bus_pkg::REG_IO);

   ////////////////////
   // Memories
   ////////////////////

   logic [7:0]                         ram_data;
   logic [7:0]                         vram_data;
   logic [7:0]                         video_data;
   logic [orao_video_pkg::VRAM_AW-1:0] video_addr;
   logic [7:0]                         io_data;

   orao_ram ram (
      .clk   (clk),
      .we    (ram_we),
      .addr  (bus.addr[14:0]),
      .wdata (bus.wdata),
      .rdata (ram_data)
   );

   orao_vram vidram (
      .clk     (clk),
      .a_we    (vram_we),
      .a_addr  (bus.addr[12:0]),
      .a_wdata (bus.wdata),
      .a_rdata (vram_data),
      .b_addr  (video_addr),
      .b_rdata (video_data)
   );

   ////////////////////
   // Video and I/O
   ////////////////////

   orao_video vid (
      .clk       (clk),
      .reset     (reset),
      .vram_addr (video_addr),
      .vram_data (video_data),
      .video     (video)
   );

   orao_io io (
      .clk     (clk),
      .reset   (reset),
      .bus     (bus),
      .io_we   (io_we),
      .ps2_key (ps2_key),
      .rdata   (io_data),
      .audio   (audio)
   );

   ////////////////////
   // Read mux
   ////////////////////

   // Region follows the one-cycle read latency of the blocks
   always_ff @(posedge clk) begin
      if (reset) begin
         region_q <= orao_bus_pkg::REG_NONE;
      end else begin
         region_q <= region;
      end
   end

   always_comb begin
      case (region_q)
         orao_bus_pkg::REG_RAM:  data_out = ram_data;
         orao_bus_pkg::REG_VRAM: data_out = vram_data;
         orao_bus_pkg::REG_IO:   data_out = io_data;
         default:                data_out = orao_bus_pkg::UNMAPPED_DATA;
      endcase
   end

endmodule

// File: verification/orao_hw_tb.sv
`timescale 1ns/1ps

module orao_hw_tb;

   ////////////////////
   // Constants
   ////////////////////

   localparam int CLK_PERIOD = 4;
   localparam int H_VISIBLE  = orao_video_pkg::H_VISIBLE;
   localparam int H_TOTAL    = orao_video_pkg::H_TOTAL;
   localparam int HS_CYCLES  = orao_video_pkg::H_SYNC_END - orao_video_pkg::H_SYNC_START;
   localparam int V_VISIBLE  = orao_video_pkg::V_VISIBLE;
   localparam int VS_LINES   = orao_video_pkg::V_SYNC_END - orao_video_pkg::V_SYNC_START;

   // Test lengths
   localparam int N_RAM      = 200;
   localparam int N_UNMAP    = 50;
   localparam int VRAM_BYTES = 8192;
   localparam int N_KEYS     = 80;
   localparam int N_SPK      = 40;

   // Two frames plus the bus tests with a margin of two
   localparam int FRAME_CYCLES = H_TOTAL * orao_video_pkg::V_TOTAL;
   localparam int BUS_CYCLES   = 2 * N_RAM + 5 * N_UNMAP + 2 * VRAM_BYTES + 2 * N_KEYS
                                 + 2 * N_SPK;
   localparam int LIMIT_NS     = 2 * (2 * FRAME_CYCLES + BUS_CYCLES) * CLK_PERIOD;

   // DUT ports
   logic                       clk;
   logic                       reset;
   orao_bus_pkg::cpu_bus_t     bus;
   orao_bus_pkg::ps2_event_t   ps2_key;
   logic [7:0]                 data_out;
   orao_video_pkg::video_out_t video;
   logic                       audio;

   // RAM and VRAM share one 64 KB model image
   logic [7:0]   mem_model [65536];
   // Bit code[6:0] is 1 while the key is released
   logic [127:0] key_model;
   logic         audio_exp;

   // Read check pipeline
   logic       rd_pending;
   logic [7:0] rd_expect;
   logic       spk_toggle;
   logic       chk_valid;
   logic [7:0] chk_data;

   // Stimulus state and counters
   int          seed;
   int          errors;
   int          err_mark;
   int          tests;
   int          tests_failed;
   int          rst_cnt;
   logic [15:0] ram_addrs [N_RAM];
   logic [15:0] stim_addr;
   logic [7:0]  stim_data;

   // Raster monitor
   logic hs_prev;
   logic vs_prev;
   logic de_prev;
   logic line_seen;
   logic frame_seen;
   logic frame_done;
   int   line_cyc;
   int   hs_low;
   int   de_cyc;
   int   hb_cyc;
   int   de_lines;
   int   vs_lines;
   int   vb_lines;

   // Picture monitor
   logic pix_req;
   logic pix_arm;
   logic pix_done;
   logic exp_pix;
   int   pix_x;
   int   pix_y;

   orao_hw dut (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .data_out (data_out),
      .video    (video),
      .ps2_key  (ps2_key),
      .audio    (audio)
   );

   always #2 clk = !clk;

   ////////////////////
   // Helpers
   ////////////////////

   // Read value from the memory map rules
   function automatic logic [7:0] expected_read(input logic [15:0] addr);
      if (addr < 16'h8000) begin
         return mem_model[addr];
      end else if (addr >= 16'h8800 && addr < 16'hA000) begin
         return key_model[addr[3:0] * 8 +: 8];
      end
      return 8'hFF;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("** Error: %s expected %0h got %0h at %0t ns", name, exp, act, $time);
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%s at %0t ns", msg, $time);
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != err_mark) begin
         tests_failed++;
      end
      $display("Test %s finished with %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   // One bus cycle that updates the model as the write lands
   task automatic drive_bus(input logic [15:0] addr, input logic [7:0] wdata,
                            input logic we, input logic rd);
      @(posedge clk);
      #1;
      bus.addr   = addr;
      bus.wdata  = wdata;
      bus.we     = we;
      rd_pending = rd;
      rd_expect  = expected_read(addr);
      spk_toggle = we && addr >= 16'h8000 && addr < 16'h8800;
      if (we && addr < 16'h8000) begin
         mem_model[addr] = wdata;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_bus(16'h0000, 8'h00, 1'b0, 1'b0);
   endtask

   // Key event on a strobe toggle followed by a read of its row
   task automatic send_key(input logic [7:0] code, input logic pressed,
                           input logic extended);
      @(posedge clk);
      #1;
      ps2_key.strobe   = !ps2_key.strobe;
      ps2_key.pressed  = pressed;
      ps2_key.extended = extended;
      ps2_key.code     = code;
      bus.we           = 1'b0;
      rd_pending       = 1'b0;
      spk_toggle       = 1'b0;
      if (!extended && !code[7]) begin
         key_model[code[6:0]] = !pressed;
      end
      drive_bus(16'h8800 + 16'(code[6:3]), 8'h00, 1'b0, 1'b1);
   endtask

   ////////////////////
   // Bus checks
   ////////////////////

   // Expected data and audio follow the DUT by one clock
   always @(posedge clk) begin
      chk_valid <= rd_pending;
      chk_data  <= rd_expect;
      if (spk_toggle) begin
         audio_exp <= !audio_exp;
      end
      if (reset) begin
         rst_cnt <= rst_cnt + 1;
      end
   end

   // Outputs are compared on the falling edge
   always @(negedge clk) begin
      if (reset) begin
         if (rst_cnt > 0) begin
            assert (video.hsync && video.vsync && !video.de && !audio)
               else report_failure("Syncs, de or audio not idle in reset");
         end
      end else begin
         if (chk_valid) begin
            assert (data_out === chk_data)
               else report_mismatch("data_out", chk_data, data_out);
         end
         assert (audio === audio_exp)
            else report_mismatch("audio", audio_exp, audio);
      end
   end

   ////////////////////
   // Video checks
   ////////////////////

   always @(negedge clk) begin
      if (reset) begin
         hs_prev    = 1'b1;
         vs_prev    = 1'b1;
         de_prev    = 1'b0;
         line_seen  = 1'b0;
         frame_seen = 1'b0;
         frame_done = 1'b0;
         pix_arm    = 1'b0;
         pix_done   = 1'b0;
      end else begin
         // Frame boundary on vsync falling
         if (vs_prev && !video.vsync) begin
            if (frame_seen) begin
               assert (de_lines == V_VISIBLE)
                  else report_mismatch("de lines per frame", V_VISIBLE, de_lines);
               assert (vs_lines == VS_LINES)
                  else report_mismatch("vsync low lines", VS_LINES, vs_lines);
               assert (vb_lines == V_VISIBLE)
                  else report_mismatch("vblank low lines", V_VISIBLE, vb_lines);
               frame_done = 1'b1;
            end
            frame_seen = 1'b1;
            de_lines   = 0;
            vs_lines   = 0;
            vb_lines   = 0;
            if (pix_req && !pix_done) begin
               pix_arm = 1'b1;
               pix_x   = 0;
               pix_y   = 0;
            end
         end
         // Line boundary on hsync falling
         if (hs_prev && !video.hsync) begin
            if (line_seen) begin
               assert (line_cyc == H_TOTAL)
                  else report_mismatch("line length", H_TOTAL, line_cyc);
               assert (hs_low == HS_CYCLES)
                  else report_mismatch("hsync low cycles", HS_CYCLES, hs_low);
               assert (de_cyc == 0 || de_cyc == H_VISIBLE)
                  else report_mismatch("de cycles per line", H_VISIBLE, de_cyc);
               assert (hb_cyc == H_VISIBLE)
                  else report_mismatch("hblank low cycles", H_VISIBLE, hb_cyc);
            end
            line_seen = 1'b1;
            line_cyc  = 0;
            hs_low    = 0;
            de_cyc    = 0;
            hb_cyc    = 0;
            if (!video.vsync) begin
               vs_lines++;
            end
            if (!video.vblank) begin
               vb_lines++;
            end
         end
         line_cyc++;
         if (!video.hsync) begin
            hs_low++;
         end
         if (video.de) begin
            de_cyc++;
         end
         if (!video.hblank) begin
            hb_cyc++;
         end
         if (video.de && !de_prev) begin
            de_lines++;
         end
         assert (video.de || !video.pix)
            else report_failure("Pixel set outside de");
         assert (!video.de || (!video.hblank && !video.vblank))
            else report_failure("de high during blanking");
         // x counts de cycles in a line and y counts de lines
         if (pix_arm && video.de) begin
            exp_pix = mem_model[16'h6000 + pix_y * 32 + pix_x / 8][pix_x % 8];
            assert (video.pix === exp_pix)
               else report_mismatch($sformatf("video.pix at x %0d y %0d", pix_x, pix_y),
                                    exp_pix, video.pix);
            pix_x++;
            if (pix_x == H_VISIBLE) begin
               pix_x = 0;
               pix_y++;
               if (pix_y == V_VISIBLE) begin
                  pix_arm  = 1'b0;
                  pix_done = 1'b1;
               end
            end
         end
         hs_prev = video.hsync;
         vs_prev = video.vsync;
         de_prev = video.de;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      seed         = 32'h14b2;
      clk          = 1'b0;
      reset        = 1'b1;
      bus          = '0;
      ps2_key      = '0;
      rd_pending   = 1'b0;
      rd_expect    = 8'hFF;
      spk_toggle   = 1'b0;
      audio_exp    = 1'b0;
      key_model    = '1;
      errors       = 0;
      err_mark     = 0;
      tests        = 0;
      tests_failed = 0;
      rst_cnt      = 0;
      pix_req      = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      // Random writes to main RAM and reads of the same addresses
      for (int i = 0; i < N_RAM; i++) begin
         ram_addrs[i] = 16'($unsigned($random(seed)) % 32'h6000);
         drive_bus(ram_addrs[i], 8'($random(seed)), 1'b1, 1'b0);
      end
      for (int i = 0; i < N_RAM; i++) begin
         drive_bus(ram_addrs[i], 8'h00, 1'b0, 1'b1);
      end
      idle_cycles(2);
      end_test("main RAM");

      // Unmapped writes must not reach the RAM alias
      for (int i = 0; i < N_UNMAP; i++) begin
         stim_addr = 16'hA000 + 16'($unsigned($random(seed)) % 32'h4000);
         stim_data = 8'($random(seed));
         drive_bus(stim_addr & 16'h7FFF, stim_data, 1'b1, 1'b0);
         drive_bus(stim_addr, ~stim_data, 1'b1, 1'b0);
         drive_bus(stim_addr, 8'h00, 1'b0, 1'b1);
         drive_bus(stim_addr & 16'h7FFF, 8'h00, 1'b0, 1'b1);
         drive_bus(16'hE000 | {3'b000, stim_addr[12:0]}, 8'h00, 1'b0, 1'b1);
      end
      idle_cycles(2);
      end_test("unmapped space");

      // Fill the whole frame buffer and read it back
      for (int i = 0; i < VRAM_BYTES; i++) begin
         drive_bus(16'h6000 + 16'(i), 8'($random(seed)), 1'b1, 1'b0);
      end
      for (int i = 0; i < VRAM_BYTES; i++) begin
         drive_bus(16'h6000 + 16'(i), 8'h00, 1'b0, 1'b1);
      end
      idle_cycles(2);
      end_test("video RAM");
      // Picture check starts at the next vsync
      pix_req = 1'b1;

      // Presses and releases with some extended events
      for (int i = 0; i < N_KEYS; i++) begin
         stim_data = 8'($random(seed)) & 8'h7F;
         send_key(stim_data, 1'($random(seed)), (($random(seed) & 3) == 0));
      end
      idle_cycles(2);
      end_test("keyboard");

      // Every other write lands below 8800
      for (int i = 0; i < N_SPK; i++) begin
         if (i % 2 == 0) begin
            stim_addr = 16'h8000 + 16'($unsigned($random(seed)) % 32'h0800);
         end else begin
            stim_addr = 16'h8000 + 16'($unsigned($random(seed)) % 32'h2000);
         end
         drive_bus(stim_addr, 8'($random(seed)), 1'b1, 1'b0);
         idle_cycles(1);
      end
      idle_cycles(2);
      end_test("speaker");

      wait (pix_done && frame_done);
      end_test("picture and raster timing");

      $display("Summary: %0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(LIMIT_NS);
      $display("Timeout, the run did not finish within %0d ns", LIMIT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: project.f
rtl/orao_bus_pkg.sv
rtl/orao_video_pkg.sv
rtl/orao_ram.sv
rtl/orao_vram.sv
rtl/orao_video.sv
rtl/orao_io.sv
rtl/orao_hw.sv
verification/orao_hw_tb.sv

// File: Bender.yml
package:
  name: orao_hw

sources:
  - rtl/orao_bus_pkg.sv
  - rtl/orao_video_pkg.sv
  - rtl/orao_ram.sv
  - rtl/orao_vram.sv
  - rtl/orao_video.sv
  - rtl/orao_io.sv
  - rtl/orao_hw.sv
  - target: simulation
    files:
      - verification/orao_hw_tb.sv
